//--- source/tsc_pkg.sv
package tsc_pkg;

    typedef logic [15:0] word_t;     // Data or address word.
    typedef logic [1:0]  reg_idx_t;  // Register index.
    typedef logic [3:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [7:0]  imm_t;

    // Opcodes, instruction bits 15 to 12.
    localparam opcode_t op_bne   = 4'd0;
    localparam opcode_t op_beq   = 4'd1;
    localparam opcode_t op_bgz   = 4'd2;
    localparam opcode_t op_blz   = 4'd3;
    localparam opcode_t op_adi   = 4'd4;
    localparam opcode_t op_ori   = 4'd5;
    localparam opcode_t op_lhi   = 4'd6;
    localparam opcode_t op_lwd   = 4'd7;
    localparam opcode_t op_swd   = 4'd8;
    localparam opcode_t op_jmp   = 4'd9;
    localparam opcode_t op_jal   = 4'd10;
    localparam opcode_t op_rtype = 4'd15;

    // R-type function codes.
    localparam func_t func_add = 6'd0;
    localparam func_t func_sub = 6'd1;
    localparam func_t func_and = 6'd2;
    localparam func_t func_orr = 6'd3;
    localparam func_t func_not = 6'd4;
    localparam func_t func_tcp = 6'd5;
    localparam func_t func_shl = 6'd6;
    localparam func_t func_shr = 6'd7;
    localparam func_t func_jpr = 6'd25;
    localparam func_t func_jrl = 6'd26;
    localparam func_t func_wwd = 6'd28;
    localparam func_t func_hlt = 6'd29;

    localparam reg_idx_t link_reg = 2'd2;  // Written by JAL and JRL.

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_not, alu_tcp,
        alu_shl, alu_shr, alu_pass_b, alu_lhi, alu_bcmp
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_mem, st_writeback, st_halted
    } seq_state_e;

    // Field extraction.
    function automatic opcode_t get_opcode(word_t i);
        return i[15:12];
    endfunction

    function automatic func_t get_func(word_t i);
        return i[5:0];
    endfunction

    function automatic reg_idx_t get_rs(word_t i);
        return i[11:10];
    endfunction

    function automatic reg_idx_t get_rt(word_t i);
        return i[9:8];
    endfunction

    function automatic reg_idx_t get_rd(word_t i);
        return i[7:6];
    endfunction

    function automatic imm_t get_imm(word_t i);
        return i[7:0];
    endfunction

    function automatic logic [11:0] get_target(word_t i);
        return i[11:0];
    endfunction

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder
    import tsc_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_load,
    input  word_t   inst,
    output logic    wwd,
    output logic    reg_write,
    output logic    mem_to_reg,
    output logic    mem_write,
    output logic    mem_read,
    output logic    is_branch,
    output logic    alu_src,
    output logic    is_alu,
    output logic    is_jump_r,
    output logic    is_jump_i,
    output logic    link,
    output alu_op_e alu_op,
    output logic    is_halted
);

    opcode_t    opcode;
    func_t      func;
    logic [9:0] ctrl_next;  // Same bit order as the outputs below.
    logic [9:0] ctrl_q;
    alu_op_e    alu_op_next;
    logic       link_next;
    logic       halt_next;

    assign opcode = get_opcode(inst);
    assign func   = get_func(inst);

    always_comb begin
        ctrl_next   = 10'b0000000000;
        alu_op_next = alu_add;
        link_next   = 1'b0;
        halt_next   = 1'b0;
        case (opcode)
            op_rtype: begin
                if (func[5:3] == 3'b000) begin
                    ctrl_next = 10'b0010000010;  // ALU op, register write.
                    case (func)
                        func_sub: alu_op_next = alu_sub;
                        func_and: alu_op_next = alu_and;
                        func_orr: alu_op_next = alu_or;
                        func_not: alu_op_next = alu_not;
                        func_tcp: alu_op_next = alu_tcp;
                        func_shl: alu_op_next = alu_shl;
                        func_shr: alu_op_next = alu_shr;
                        default:  alu_op_next = alu_add;
                    endcase
                end else if (func == func_wwd) begin
                    ctrl_next   = 10'b0000000001;
                    alu_op_next = alu_pass_b;
                end else if (func == func_jpr) begin
                    ctrl_next   = 10'b0100000000;
                    alu_op_next = alu_pass_b;
                end else if (func == func_jrl) begin
                    ctrl_next   = 10'b0100000010;
                    alu_op_next = alu_pass_b;
                    link_next   = 1'b1;
                end else if (func == func_hlt) begin
                    halt_next = 1'b1;
                end
            end
            op_adi:  ctrl_next = 10'b0001000010;
            op_ori: begin
                ctrl_next   = 10'b0001000010;
                alu_op_next = alu_or;
            end
            op_lhi: begin
                ctrl_next   = 10'b0001000010;
                alu_op_next = alu_lhi;
            end
            op_lwd:  ctrl_next = 10'b0001010110;  // Address is rs plus offset.
            op_swd:  ctrl_next = 10'b0001001000;
            op_bne, op_beq, op_bgz, op_blz: begin
                ctrl_next   = 10'b0000100000;
                alu_op_next = alu_bcmp;
            end
            op_jmp: begin
                ctrl_next   = 10'b1000000000;
                alu_op_next = alu_pass_b;
            end
            op_jal: begin
                ctrl_next   = 10'b1000000010;
                alu_op_next = alu_pass_b;
                link_next   = 1'b1;
            end
            default: ctrl_next = 10'b0000000000;  // Unknown opcode runs as a no-op.
        endcase
    end

    // Halt is sticky, later loads are ignored.
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q    <= 10'b0000000000;
            alu_op    <= alu_add;
            link      <= 1'b0;
            is_halted <= 1'b0;
        end else if (inst_load && !is_halted) begin
            ctrl_q    <= ctrl_next;
            alu_op    <= alu_op_next;
            link      <= link_next;
            is_halted <= halt_next;
        end
    end

    assign wwd        = ctrl_q[0];
    assign reg_write  = ctrl_q[1];
    assign mem_to_reg = ctrl_q[2];
    assign mem_write  = ctrl_q[3];
    assign mem_read   = ctrl_q[4];
    assign is_branch  = ctrl_q[5];
    assign alu_src    = ctrl_q[6];
    assign is_alu     = ctrl_q[7];
    assign is_jump_r  = ctrl_q[8];
    assign is_jump_i  = ctrl_q[9];

endmodule

//--- source/register_file.sv
`timescale 1ns/10ps

module register_file
    import tsc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd_addr_a,
    input  reg_idx_t rd_addr_b,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    output word_t    rd_data_a,
    output word_t    rd_data_b
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads, no bypass of a same-cycle write.
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

//--- source/alu.sv
`timescale 1ns/10ps

module alu
    import tsc_pkg::*;
(
    input  alu_op_e alu_op,
    input  word_t   a,
    input  word_t   b,
    input  opcode_t cond,
    output word_t   result,
    output logic    taken
);

    logic cond_met;

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_not:    result = ~a;
            alu_tcp:    result = ~a + 16'd1;
            alu_shl:    result = {a[14:0], 1'b0};
            alu_shr:    result = {a[15], a[15:1]};  // Arithmetic.
            alu_pass_b: result = b;
            alu_lhi:    result = {b[7:0], 8'h00};
            alu_bcmp:   result = a - b;
            default:    result = a + b;
        endcase
    end

    // Branch condition from the opcode.
    always_comb begin
        case (cond)
            op_bne:  cond_met = (a != b);
            op_beq:  cond_met = (a == b);
            op_bgz:  cond_met = !a[15] && (a != 16'd0);
            op_blz:  cond_met = a[15];
            default: cond_met = 1'b0;
        endcase
    end

    assign taken = (alu_op == alu_bcmp) && cond_met;

endmodule

//--- source/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer
    import tsc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     wwd,
    input  logic     reg_write,
    input  logic     mem_to_reg,
    input  logic     mem_write,
    input  logic     mem_read,
    input  logic     is_branch,
    input  logic     alu_src,
    input  logic     is_alu,
    input  logic     is_jump_r,
    input  logic     is_jump_i,
    input  logic     link,
    input  alu_op_e  alu_op,
    input  logic     is_halted,
    input  word_t    rd_data_a,
    input  word_t    rd_data_b,
    input  word_t    result,
    input  logic     taken,
    input  word_t    wb_dat_r,
    input  logic     wb_ack,
    output logic     inst_load,
    output word_t    inst,
    output reg_idx_t rd_addr_a,
    output reg_idx_t rd_addr_b,
    output logic     wr_en,
    output reg_idx_t wr_addr,
    output word_t    wr_data,
    output word_t    alu_a,
    output word_t    alu_b,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output word_t    wb_adr,
    output word_t    wb_dat_w,
    output word_t    out_data,
    output logic     out_valid
);

    seq_state_e state;
    word_t      pc;
    word_t      ir;       // Instruction register.
    word_t      res_q;    // ALU result or link value.
    word_t      mem_q;    // Load data.
    word_t      pc_inc;
    word_t      next_pc;
    word_t      imm_ext;
    imm_t       imm;

    assign imm     = get_imm(ir);
    assign pc_inc  = pc + 16'd1;

    // ORI zero-extends, all other immediates are signed.
    assign imm_ext = (alu_op == alu_or) ? {8'h00, imm} : {{8{imm[7]}}, imm};

    assign inst_load = (state == st_fetch) && wb_cyc && wb_ack;
    assign inst      = inst_load ? wb_dat_r : ir;

    assign rd_addr_a = get_rs(ir);
    assign rd_addr_b = get_rt(ir);
    assign alu_a     = rd_data_a;
    assign alu_b     = alu_src ? imm_ext : rd_data_b;

    assign wr_en   = (state == st_writeback) && reg_write;
    assign wr_addr = link ? link_reg : (is_alu ? get_rd(ir) : get_rt(ir));
    assign wr_data = mem_to_reg ? mem_q : res_q;

    always_comb begin
        next_pc = pc_inc;
        if (is_branch && taken) begin
            next_pc = pc_inc + {{8{imm[7]}}, imm};
        end else if (is_jump_i) begin
            next_pc = {pc[15:12], get_target(ir)};
        end else if (is_jump_r) begin
            next_pc = rd_data_a;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_fetch;
            pc        <= '0;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            wb_we     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;  // One-cycle strobe.
            case (state)
                st_fetch: begin
                    if (!wb_cyc) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                        wb_adr <= pc;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        ir     <= wb_dat_r;
                        state  <= st_decode;
                    end
                end
                st_decode: state <= is_halted ? st_halted : st_execute;
                st_execute: begin
                    pc    <= next_pc;
                    res_q <= link ? pc_inc : result;
                    if (wwd) begin
                        out_data  <= rd_data_a;
                        out_valid <= 1'b1;
                    end
                    if (mem_read || mem_write) begin
                        state <= st_mem;
                    end else if (reg_write) begin
                        state <= st_writeback;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_mem: begin
                    if (!wb_cyc) begin
                        wb_cyc   <= 1'b1;
                        wb_stb   <= 1'b1;
                        wb_we    <= mem_write;
                        wb_adr   <= result;    // rs plus offset.
                        wb_dat_w <= rd_data_b;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        mem_q  <= wb_dat_r;
                        state  <= mem_read ? st_writeback : st_fetch;
                    end
                end
                st_writeback: state <= st_fetch;
                default: state <= st_halted;  // Halted, no more bus cycles.
            endcase
        end
    end

endmodule

//--- source/cpu_top.sv
`timescale 1ns/10ps

module cpu_top
    import tsc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t wb_dat_r,
    input  logic  wb_ack,
    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output word_t wb_adr,
    output word_t wb_dat_w,
    output word_t out_data,
    output logic  out_valid,
    output logic  is_halted
);

    // Decoder control signals.
    logic     wwd;
    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_write;
    logic     mem_read;
    logic     is_branch;
    logic     alu_src;
    logic     is_alu;
    logic     is_jump_r;
    logic     is_jump_i;
    logic     link;
    alu_op_e  alu_op;

    logic     inst_load;
    word_t    inst;
    reg_idx_t rd_addr_a;
    reg_idx_t rd_addr_b;
    word_t    rd_data_a;
    word_t    rd_data_b;
    logic     wr_en;
    reg_idx_t wr_addr;
    word_t    wr_data;
    word_t    alu_a;
    word_t    alu_b;
    word_t    result;
    logic     taken;

    cpu_sequencer u_sequencer (
        .clk(clk), .rst(rst),
        .wwd(wwd), .reg_write(reg_write), .mem_to_reg(mem_to_reg),
        .mem_write(mem_write), .mem_read(mem_read), .is_branch(is_branch),
        .alu_src(alu_src), .is_alu(is_alu), .is_jump_r(is_jump_r),
        .is_jump_i(is_jump_i), .link(link), .alu_op(alu_op), .is_halted(is_halted),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .result(result), .taken(taken),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .inst_load(inst_load), .inst(inst),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .alu_a(alu_a), .alu_b(alu_b),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .out_data(out_data), .out_valid(out_valid)
    );

    inst_decoder u_decoder (
        .clk(clk), .rst(rst), .inst_load(inst_load), .inst(inst),
        .wwd(wwd), .reg_write(reg_write), .mem_to_reg(mem_to_reg),
        .mem_write(mem_write), .mem_read(mem_read), .is_branch(is_branch),
        .alu_src(alu_src), .is_alu(is_alu), .is_jump_r(is_jump_r),
        .is_jump_i(is_jump_i), .link(link), .alu_op(alu_op), .is_halted(is_halted)
    );

    register_file u_regs (
        .clk(clk), .rst(rst),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

    // Branch condition comes from the held instruction's opcode.
    alu u_alu (
        .alu_op(alu_op), .a(alu_a), .b(alu_b), .cond(get_opcode(inst)),
        .result(result), .taken(taken)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- testbench/tb_wb_memory.sv
`timescale 1ns/10ps

module tb_wb_memory
    import tsc_pkg::*;
#(
    parameter logic [31:0] seed = 32'h7c4595af
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  logic  wb_we,
    input  word_t wb_adr,
    input  word_t wb_dat_w,
    output word_t wb_dat_r,
    output logic  wb_ack
);

    word_t       mem [256];  // Loaded by the testbench top.
    logic [31:0] rng;
    logic        busy;
    logic [1:0]  wait_left;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Slave outputs idle from time zero.
    initial begin
        wb_ack   = 1'b0;
        wb_dat_r = '0;
    end

    // Responses change on the falling edge.
    always @(negedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            busy      <= 1'b0;
            wait_left <= 2'd0;
            rng       <= seed;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!busy) begin
                    busy      <= 1'b1;
                    rng       <= xorshift32(rng);
                    wait_left <= rng[1:0];  // One to four cycles to ack.
                end else if (wait_left == 2'd0) begin
                    busy   <= 1'b0;
                    wb_ack <= 1'b1;
                    if (wb_we) begin
                        mem[wb_adr[7:0]] <= wb_dat_w;
                    end else begin
                        wb_dat_r <= mem[wb_adr[7:0]];
                    end
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

endmodule

//--- testbench/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu
    import tsc_pkg::*;
;

    localparam int prog_len       = 60;
    localparam int timeout_cycles = prog_len * 12 + 200;

    logic  clk;
    logic  rst;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    word_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic  wb_ack;
    word_t out_data;
    logic  out_valid;
    logic  is_halted;

    logic [31:0] rng;
    word_t       prog [prog_len];
    word_t       m_regs [4];
    word_t       m_mem [256];
    logic        exp_we [$];   // Expected bus accesses in order.
    word_t       exp_adr [$];
    word_t       exp_dat [$];
    word_t       exp_out [$];  // Expected WWD values.
    int          errors;
    int          out_count;
    int          model_outs;
    int          cycles;
    logic        prev_req;
    logic        prev_ack;
    word_t       prev_adr;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    tb_wb_memory #(.seed(32'h7c4595af)) u_mem (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    cpu_top u_dut (
        .clk(clk), .rst(rst),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .out_data(out_data), .out_valid(out_valid), .is_halted(is_halted)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Base register r3 is set up first and never overwritten.
    task automatic build_program();
        logic [31:0] r;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    dst;
        imm_t        imm;
        int          k;
        prog[0] = {op_lhi, 2'd0, 2'd3, 8'h00};
        prog[1] = {op_ori, 2'd3, 2'd3, 8'h80};  // r3 = 128.
        for (int i = 2; i < 55; i++) begin
            rng = xorshift32(rng);
            r   = rng;
            rs  = r[9:8];
            rt  = r[11:10];
            dst = r[13:12] % 3;
            imm = r[23:16];
            k   = (r[29:28] > 54 - i) ? 54 - i : r[29:28];
            if (i % 5 == 4) begin
                prog[i] = {op_rtype, rs, 2'd0, 2'd0, func_wwd};
            end else begin
                case (r[3:0] % 10)
                    0, 1, 2: prog[i] = {op_rtype, rs, rt, dst, 3'b000, r[26:24]};
                    3:       prog[i] = {op_adi, rs, dst, imm};
                    4:       prog[i] = {op_ori, rs, dst, imm};
                    5:       prog[i] = {op_lhi, rs, dst, imm};
                    6:       prog[i] = {op_lwd, 2'd3, dst, 2'b00, imm[5:0]};
                    7:       prog[i] = {op_swd, 2'd3, rt, 2'b00, imm[5:0]};
                    8:       prog[i] = {2'b00, r[31:30], rs, rt, 8'(k)};  // Forward branch.
                    default: prog[i] = {(r[30] ? op_jal : op_jmp), 12'(i + 1 + k)};
                endcase
            end
        end
        for (int i = 0; i < 4; i++) begin
            prog[55 + i] = {op_rtype, 2'(i), 2'd0, 2'd0, func_wwd};
        end
        prog[59] = {op_rtype, 6'd0, func_hlt};
    endtask

    // Instruction-set model, records every bus access and WWD value.
    task automatic run_model();
        word_t    pc;
        word_t    npc;
        word_t    ins;
        word_t    simm;
        word_t    addr;
        reg_idx_t rs;
        reg_idx_t rt;
        logic     done;
        logic     cond;
        int       steps;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 500) begin
            steps++;
            ins  = m_mem[pc[7:0]];
            exp_we.push_back(1'b0);
            exp_adr.push_back(pc);
            exp_dat.push_back(ins);
            rs   = ins[11:10];
            rt   = ins[9:8];
            simm = {{8{ins[7]}}, ins[7:0]};
            npc  = pc + 16'd1;
            case (ins[15:12])
                op_rtype: begin
                    case (ins[5:0])
                        6'd0: m_regs[ins[7:6]] = m_regs[rs] + m_regs[rt];
                        6'd1: m_regs[ins[7:6]] = m_regs[rs] - m_regs[rt];
                        6'd2: m_regs[ins[7:6]] = m_regs[rs] & m_regs[rt];
                        6'd3: m_regs[ins[7:6]] = m_regs[rs] | m_regs[rt];
                        6'd4: m_regs[ins[7:6]] = ~m_regs[rs];
                        6'd5: m_regs[ins[7:6]] = 16'd0 - m_regs[rs];
                        6'd6: m_regs[ins[7:6]] = m_regs[rs] << 1;
                        6'd7: m_regs[ins[7:6]] = {m_regs[rs][15], m_regs[rs][15:1]};
                        func_jpr: npc = m_regs[rs];
                        func_jrl: begin
                            npc            = m_regs[rs];
                            m_regs[link_reg] = pc + 16'd1;
                        end
                        func_wwd: exp_out.push_back(m_regs[rs]);
                        func_hlt: done = 1'b1;
                        default: ;
                    endcase
                end
                op_adi: m_regs[rt] = m_regs[rs] + simm;
                op_ori: m_regs[rt] = m_regs[rs] | {8'h00, ins[7:0]};
                op_lhi: m_regs[rt] = {ins[7:0], 8'h00};
                op_lwd: begin
                    addr = m_regs[rs] + simm;
                    exp_we.push_back(1'b0);
                    exp_adr.push_back(addr);
                    exp_dat.push_back(m_mem[addr[7:0]]);
                    m_regs[rt] = m_mem[addr[7:0]];
                end
                op_swd: begin
                    addr = m_regs[rs] + simm;
                    exp_we.push_back(1'b1);
                    exp_adr.push_back(addr);
                    exp_dat.push_back(m_regs[rt]);
                    m_mem[addr[7:0]] = m_regs[rt];
                end
                op_bne, op_beq, op_bgz, op_blz: begin
                    case (ins[13:12])
                        2'd0:    cond = m_regs[rs] != m_regs[rt];
                        2'd1:    cond = m_regs[rs] == m_regs[rt];
                        2'd2:    cond = $signed(m_regs[rs]) > 0;
                        default: cond = $signed(m_regs[rs]) < 0;
                    endcase
                    if (cond) begin
                        npc = pc + 16'd1 + simm;
                    end
                end
                op_jmp: npc = {pc[15:12], ins[11:0]};
                op_jal: begin
                    npc              = {pc[15:12], ins[11:0]};
                    m_regs[link_reg] = pc + 16'd1;
                end
                default: ;  // Undefined opcodes are no-ops.
            endcase
            pc = npc;
        end
    endtask

    // Bus monitor: access contents, handshake stability and idle cycles.
    always @(posedge clk) begin
        if (rst) begin
            prev_req <= 1'b0;
            prev_ack <= 1'b0;
            prev_adr <= '0;
        end else begin
            if (prev_req && !prev_ack) begin
                if (!(wb_cyc && wb_stb)) begin
                    errors++;
                    $display("Strobe dropped before the slave acknowledged the access");
                end else if (wb_adr !== prev_adr) begin
                    errors++;
                    $display("Address changed while the access was waiting for ack");
                end
            end
            if (prev_req && prev_ack && wb_cyc && wb_stb) begin
                errors++;
                $display("No idle cycle between two bus accesses");
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                if (exp_adr.size() == 0) begin
                    errors++;
                    $display("Bus access at address %h that the model does not expect", wb_adr);
                end else begin
                    check_value("wb_we", 16'(wb_we), 16'(exp_we[0]));
                    check_value("wb_adr", wb_adr, exp_adr[0]);
                    if (exp_we[0]) begin
                        check_value("wb_dat_w", wb_dat_w, exp_dat[0]);
                    end else begin
                        check_value("wb_dat_r", wb_dat_r, exp_dat[0]);
                    end
                    void'(exp_we.pop_front());
                    void'(exp_adr.pop_front());
                    void'(exp_dat.pop_front());
                end
            end
            if (out_valid) begin
                out_count++;
                if (exp_out.size() == 0) begin
                    errors++;
                    $display("WWD output %h with no more values expected", out_data);
                end else begin
                    check_value("out_data", out_data, exp_out.pop_front());
                end
            end
            prev_req <= wb_cyc && wb_stb;
            prev_ack <= wb_ack;
            prev_adr <= wb_adr;
        end
    end

    initial begin
        errors    = 0;
        out_count = 0;
        cycles    = 0;
        rng       = 32'h7c4595af;
        for (int a = 0; a < 256; a++) begin
            m_mem[a] = 16'(a * 16'h0101) ^ 16'h3c5a;  // Fill pattern.
        end
        for (int r = 0; r < 4; r++) begin
            m_regs[r] = '0;
        end
        build_program();
        for (int a = 0; a < prog_len; a++) begin
            m_mem[a] = prog[a];
        end
        for (int a = 0; a < 256; a++) begin
            u_mem.mem[a] = m_mem[a];
        end
        run_model();
        model_outs = exp_out.size();
        @(negedge rst);
        check_value("wb_cyc", 16'(wb_cyc), 16'h0);
        check_value("out_valid", 16'(out_valid), 16'h0);
        check_value("is_halted", 16'(is_halted), 16'h0);
        while (!is_halted && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!is_halted) begin
            $display("Timeout after %0d cycles, the processor never halted", cycles);
            $display("Simulation failed");
            $finish;
        end else begin
            repeat (50) begin
                @(negedge clk);
                if (wb_cyc) begin
                    errors++;
                    $display("A bus cycle started after the processor halted");
                end
            end
            if (exp_adr.size() != 0) begin
                errors++;
                $display("%0d expected bus accesses never happened", exp_adr.size());
            end
            check_value("wwd_count", 16'(out_count), 16'(model_outs));
            for (int a = 128; a < 192; a++) begin
                check_value($sformatf("mem[%0d]", a), u_mem.mem[a], m_mem[a]);
            end
            $display("Errors: %0d, WWD outputs: %0d of %0d, cycles: %0d",
                     errors, out_count, model_outs, cycles);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- build.f
source/tsc_pkg.sv
source/inst_decoder.sv
source/register_file.sv
source/alu.sv
source/cpu_sequencer.sv
source/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_wb_memory.sv
testbench/tb_cpu.sv

//--- Bender.yml
package:
  name: tsc_cpu

sources:
  - files:
      - source/tsc_pkg.sv
      - source/inst_decoder.sv
      - source/register_file.sv
      - source/alu.sv
      - source/cpu_sequencer.sv
      - source/cpu_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_wb_memory.sv
      - testbench/tb_cpu.sv
